// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 5
) (
    input  logic restart_i,
    output logic clk_o,
    output logic arst_n_o
);

    int rst_cnt = 0;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset length counted in falling edges, restart_i starts it over
    always @(negedge clk_o) begin
        if (restart_i) begin
            rst_cnt <= 0;
        end else if (rst_cnt < RST_CYCLES) begin
            rst_cnt <= rst_cnt + 1;
        end
    end

    assign arst_n_o = (rst_cnt >= RST_CYCLES);

endmodule

// ==== dv/tb_core.sv ====
`timescale 1ns/1ps

module tb_core import core_isa_pkg::*; ();

    localparam int PC_WIDTH     = 16;
    localparam int ROM_DEPTH    = 256;
    localparam int CYC_PER_INST = 40;

    logic                clk;
    logic                arst_n;
    logic                restart = 1'b0;

    logic                ibus_cyc;
    logic                ibus_stb;
    logic [PC_WIDTH-1:0] ibus_adr;
    inst_t               ibus_dat = '0;
    logic                ibus_ack = 1'b0;

    logic                retire_valid;
    logic [PC_WIDTH-1:0] retire_pc;
    reg_addr_t           retire_rd;
    logic                retire_we;
    word_t               retire_data;

    // program image and the retire stream it should produce
    inst_t               rom [ROM_DEPTH];
    word_t               xreg [32];
    int                  ppc;
    logic [PC_WIDTH-1:0] exp_pc [$];
    reg_addr_t           exp_rd [$];
    logic                exp_we [$];
    word_t               exp_data [$];

    logic                rand_ack    = 1'b0;
    int                  wait_left   = 0;
    int                  cycle_count = 0;
    int                  cycle_limit = 0;

    tb_clkgen #(
        .PERIOD_NS  (8),
        .RST_CYCLES (5)
    ) u_clkgen (
        .restart_i (restart),
        .clk_o     (clk),
        .arst_n_o  (arst_n)
    );

    core_top #(
        .PC_WIDTH (PC_WIDTH)
    ) DUT (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .ibus_cyc_o     (ibus_cyc),
        .ibus_stb_o     (ibus_stb),
        .ibus_adr_o     (ibus_adr),
        .ibus_dat_i     (ibus_dat),
        .ibus_ack_i     (ibus_ack),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_we_o    (retire_we),
        .retire_data_o  (retire_data)
    );

    function automatic int ack_delay();
        int d;
        d = 0;
        if (rand_ack) begin
            d = int'($urandom_range(3, 0));
        end
        return d;
    endfunction

    // wishbone slave rom answering after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (!arst_n) begin
            ibus_ack  <= 1'b0;
            wait_left <= ack_delay();
        end else if (ibus_ack) begin
            ibus_ack <= 1'b0;
        end else if (ibus_cyc && ibus_stb) begin
            if (wait_left == 0) begin
                ibus_ack  <= 1'b1;
                ibus_dat  <= rom[ibus_adr[7:0]];
                wait_left <= ack_delay();
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the core made no progress within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input logic [PC_WIDTH-1:0] got, input logic [PC_WIDTH-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input reg_addr_t got, input reg_addr_t exp,
                                  input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ISA result of the supported ALU group
    function automatic word_t alu_expect(input funct3_t f3, input logic sub,
                                         input word_t a, input word_t b);
        word_t res;
        case (f3)
            F3_ADD_SUB: res = sub ? a - b : a + b;
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_OR:      res = a | b;
            F3_AND:     res = a & b;
            default:    res = '0;
        endcase
        return res;
    endfunction

    task automatic new_program();
        int i;
        // fill decodes as addi x0, x0, address
        for (i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = {i[11:0], 13'b0, OP_I};
        end
        for (i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
        ppc = 0;
        exp_pc.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_data.delete();
    endtask

    task automatic place(input inst_t ins, input reg_addr_t rd, input logic we,
                         input word_t data, input int next_pc);
        rom[ppc] = ins;
        exp_pc.push_back(PC_WIDTH'(ppc));
        exp_rd.push_back(rd);
        exp_we.push_back(we);
        exp_data.push_back(data);
        if (we && rd != 5'd0) begin
            xreg[rd] = data;
        end
        ppc = next_pc;
    endtask

    task automatic emit_r(input logic sub, input funct3_t f3, input reg_addr_t rd,
                          input reg_addr_t rs1, input reg_addr_t rs2);
        inst_t ins;
        ins = {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP_R};
        place(ins, rd, 1'b1, alu_expect(f3, sub, xreg[rs1], xreg[rs2]), ppc + 1);
    endtask

    task automatic emit_i(input funct3_t f3, input reg_addr_t rd, input reg_addr_t rs1,
                          input logic [11:0] imm);
        inst_t ins;
        word_t simm;
        ins  = {imm, rs1, f3, rd, OP_I};
        simm = {{20{imm[11]}}, imm};
        place(ins, rd, 1'b1, alu_expect(f3, 1'b0, xreg[rs1], simm), ppc + 1);
    endtask

    task automatic emit_lui(input reg_addr_t rd, input logic [19:0] imm);
        place({imm, rd, OP_LUI}, rd, 1'b1, {imm, 12'b0}, ppc + 1);
    endtask

    // k is the offset in words past pc + 1
    task automatic emit_branch(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2,
                               input int k);
        logic [12:0] off;
        inst_t       ins;
        logic        taken;
        off   = 13'(k * 4);
        ins   = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
        taken = (f3 == F3_BNE) ? (xreg[rs1] != xreg[rs2]) : (xreg[rs1] == xreg[rs2]);
        place(ins, 5'd0, 1'b0, '0, taken ? ppc + 1 + k : ppc + 1);
    endtask

    task automatic emit_jal(input reg_addr_t rd, input int k);
        logic [20:0] off;
        inst_t       ins;
        off = 21'(k * 4);
        ins = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
        place(ins, rd, 1'b1, 32'(ppc + 1), ppc + 1 + k);
    endtask

    task automatic next_sample();
        @(negedge clk);
        #1;
    endtask

    task automatic wait_fetch();
        next_sample();
        while (!ibus_cyc) begin
            next_sample();
        end
        check_flag(ibus_stb, 1'b1, "ibus_stb_o with ibus_cyc_o");
    endtask

    task automatic wait_retire();
        next_sample();
        while (!retire_valid) begin
            next_sample();
        end
    endtask

    // reset the core, then follow the expected retire stream
    task automatic run_program(input logic random_wait);
        int n;
        rand_ack    = random_wait;
        cycle_limit = cycle_limit + CYC_PER_INST * (exp_pc.size() + 1);
        @(negedge clk);
        restart <= 1'b1;
        @(negedge clk);
        restart <= 1'b0;
        // last pass is the idle cycle right after release
        do begin
            next_sample();
            check_flag(ibus_cyc, 1'b0, "ibus_cyc_o around reset");
            check_flag(ibus_stb, 1'b0, "ibus_stb_o around reset");
            check_flag(retire_valid, 1'b0, "retire_valid_o around reset");
        end while (!arst_n);
        wait_fetch();
        check_pc(ibus_adr, '0, "first fetch address");
        for (n = 0; n < exp_pc.size(); n++) begin
            wait_retire();
            check_pc(retire_pc, exp_pc[n], "retire_pc_o");
            check_flag(retire_we, exp_we[n], "retire_we_o");
            if (exp_we[n]) begin
                check_reg_addr(retire_rd, exp_rd[n], "retire_rd_o");
                check_word(retire_data, exp_data[n], "retire_data_o");
            end
            if (n + 1 < exp_pc.size()) begin
                wait_fetch();
                check_pc(ibus_adr, exp_pc[n + 1], "next fetch address");
            end
        end
    endtask

    task automatic run_both_ack_modes();
        run_program(1'b0);
        run_program(1'b1);
    endtask

    task automatic test_alu_reg();
        new_program();
        emit_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd123);
        emit_i(F3_ADD_SUB, 5'd2, 5'd0, 12'hFD3);
        emit_i(F3_ADD_SUB, 5'd3, 5'd0, 12'h0F7);
        emit_i(F3_ADD_SUB, 5'd4, 5'd2, 12'h555);
        emit_r(1'b0, F3_ADD_SUB, 5'd10, 5'd1, 5'd2);
        emit_r(1'b1, F3_ADD_SUB, 5'd11, 5'd1, 5'd2);
        emit_r(1'b1, F3_ADD_SUB, 5'd12, 5'd2, 5'd1);
        emit_r(1'b0, F3_AND, 5'd13, 5'd2, 5'd3);
        emit_r(1'b0, F3_OR, 5'd14, 5'd1, 5'd3);
        emit_r(1'b0, F3_XOR, 5'd15, 5'd2, 5'd4);
        emit_r(1'b0, F3_SLT, 5'd16, 5'd2, 5'd1);
        emit_r(1'b0, F3_SLT, 5'd17, 5'd1, 5'd2);
        emit_r(1'b0, F3_SLT, 5'd18, 5'd1, 5'd1);
        run_both_ack_modes();
    endtask

    task automatic test_imm_lui();
        new_program();
        emit_i(F3_ADD_SUB, 5'd1, 5'd0, 12'hFFF);
        emit_i(F3_ADD_SUB, 5'd2, 5'd0, 12'h800);
        emit_i(F3_AND, 5'd3, 5'd1, 12'hF0F);
        emit_i(F3_OR, 5'd4, 5'd0, 12'hF00);
        emit_i(F3_XOR, 5'd5, 5'd4, 12'hFFF);
        emit_i(F3_SLT, 5'd6, 5'd0, 12'hFFF);
        emit_i(F3_SLT, 5'd7, 5'd2, 12'hFFB);
        emit_lui(5'd8, 20'hABCDE);
        emit_lui(5'd9, 20'h80000);
        emit_i(F3_ADD_SUB, 5'd10, 5'd9, 12'hFFF);
        run_both_ack_modes();
    endtask

    task automatic test_x0();
        new_program();
        emit_i(F3_ADD_SUB, 5'd0, 5'd0, 12'd55);
        emit_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd9);
        emit_r(1'b0, F3_ADD_SUB, 5'd0, 5'd1, 5'd1);
        emit_r(1'b0, F3_ADD_SUB, 5'd2, 5'd0, 5'd1);
        emit_r(1'b0, F3_ADD_SUB, 5'd3, 5'd0, 5'd0);
        run_both_ack_modes();
    endtask

    task automatic test_branch();
        new_program();
        emit_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd5);
        emit_i(F3_ADD_SUB, 5'd2, 5'd0, 12'd5);
        emit_i(F3_ADD_SUB, 5'd3, 5'd0, 12'd6);
        emit_branch(F3_BEQ, 5'd1, 5'd2, 2);
        emit_branch(F3_BEQ, 5'd1, 5'd3, 3);
        emit_i(F3_ADD_SUB, 5'd4, 5'd1, 12'd1);
        emit_branch(F3_BNE, 5'd1, 5'd3, 1);
        emit_branch(F3_BNE, 5'd1, 5'd2, 4);
        emit_i(F3_ADD_SUB, 5'd5, 5'd4, 12'd1);
        run_both_ack_modes();
    endtask

    task automatic test_jal();
        new_program();
        emit_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd3);
        emit_jal(5'd2, 3);
        emit_i(F3_ADD_SUB, 5'd3, 5'd2, 12'd0);
        emit_jal(5'd5, 6);
        emit_jal(5'd0, 1);
        emit_i(F3_ADD_SUB, 5'd6, 5'd5, 12'd1);
        run_both_ack_modes();
    endtask

    initial begin
        void'($urandom(18));
        test_alu_reg();
        test_imm_lui();
        test_x0();
        test_branch();
        test_jal();
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/core_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/control_unit.sv
hw/imm_gen.sv
hw/regfile.sv
hw/ifetch_wb.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/core_top.sv
dv/tb_clkgen.sv
dv/tb_core.sv

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import core_isa_pkg::*; import core_ctrl_pkg::*; (
    input  opcode_t opcode_i,
    output alu_op_e alu_op_o,
    output jump_e   jump_o,
    output wb_sel_e wb_sel_o,
    output logic    reg_we_o,
    output logic    use_imm_o
);

    always_comb begin
        // unknown opcodes fall through as a no-op
        alu_op_o  = ALU_ADD;
        jump_o    = JUMP_NONE;
        wb_sel_o  = WB_ALU;
        reg_we_o  = 1'b0;
        use_imm_o = 1'b0;
        case (opcode_i)
            OP_R: begin
                alu_op_o = ALU_FUNCT;
                reg_we_o = 1'b1;
            end
            OP_I: begin
                alu_op_o  = ALU_FUNCT;
                reg_we_o  = 1'b1;
                use_imm_o = 1'b1;
            end
            OP_LUI: begin
                alu_op_o  = ALU_PASS_IMM;
                reg_we_o  = 1'b1;
                use_imm_o = 1'b1;
            end
            OP_BRANCH: begin
                jump_o = JUMP_BRANCH;
            end
            OP_JAL: begin
                jump_o   = JUMP_JAL;
                wb_sel_o = WB_PC_PLUS;
                reg_we_o = 1'b1;
            end
            default: ;
        endcase
    end

    // jal always links
    always_comb begin
        assert (!(jump_o == JUMP_JAL && !reg_we_o))
            else $error("jal decoded without register write");
    end

endmodule

// ==== hw/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    // how the ALU picks its operation
    typedef enum logic [1:0] {
        ALU_ADD      = 2'd0,
        ALU_FUNCT    = 2'd1,
        ALU_PASS_IMM = 2'd2
    } alu_op_e;

    // kind of control transfer
    typedef enum logic [1:0] {
        JUMP_NONE   = 2'd0,
        JUMP_BRANCH = 2'd1,
        JUMP_JAL    = 2'd2
    } jump_e;

    // source of the write-back value
    typedef enum logic [1:0] {
        WB_ALU     = 2'd0,
        WB_PC_PLUS = 2'd1
    } wb_sel_e;

    // fetch sequencer
    // IDLE only after reset, then REQ and EXEC alternate
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_REQ  = 2'd1,
        FETCH_EXEC = 2'd2
    } fetch_state_e;

endpackage

// ==== hw/core_isa_pkg.sv ====
package core_isa_pkg;

    // base widths of the integer ISA
    typedef logic [31:0] inst_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes of the supported subset
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // low bit of each instruction field
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    // selects SUB over ADD and SRA over SRL
    localparam int ALT_BIT    = 30;

    // funct3 values for the ALU group
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct3 values for the branch group
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

endpackage

// ==== hw/core_top.sv ====
`timescale 1ns/1ps

module core_top import core_isa_pkg::*; import core_ctrl_pkg::*; #(
    parameter int PC_WIDTH = 16
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    output logic                ibus_cyc_o,
    output logic                ibus_stb_o,
    output logic [PC_WIDTH-1:0] ibus_adr_o,
    input  inst_t               ibus_dat_i,
    input  logic                ibus_ack_i,

    output logic                retire_valid_o,
    output logic [PC_WIDTH-1:0] retire_pc_o,
    output reg_addr_t           retire_rd_o,
    output logic                retire_we_o,
    output word_t               retire_data_o
);

    inst_t               inst;
    logic [PC_WIDTH-1:0] pc;
    logic                exec;
    logic                redirect;
    logic [PC_WIDTH-1:0] redirect_pc;

    reg_addr_t           reg1_addr;
    reg_addr_t           reg2_addr;
    word_t               rdata1;
    word_t               rdata2;
    word_t               reg1_data;
    word_t               reg2_data;

    reg_addr_t           rd_addr;
    funct3_t             funct3;
    logic                alu30;
    logic [PC_WIDTH-1:0] pc_plus;
    logic [PC_WIDTH-1:0] branch_addr;
    word_t               imm;
    alu_op_e             alu_op;
    jump_e               jump;
    wb_sel_e             wb_sel;
    logic                reg_we;
    logic                use_imm;

    logic                wb_we;
    reg_addr_t           wb_addr;
    word_t               wb_data;

    ifetch_wb #(
        .PC_WIDTH (PC_WIDTH)
    ) u_ifetch_wb (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .ibus_cyc_o    (ibus_cyc_o),
        .ibus_stb_o    (ibus_stb_o),
        .ibus_adr_o    (ibus_adr_o),
        .ibus_dat_i    (ibus_dat_i),
        .ibus_ack_i    (ibus_ack_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_o        (inst),
        .pc_o          (pc),
        .exec_o        (exec)
    );

    id_stage #(
        .PC_WIDTH (PC_WIDTH)
    ) u_id_stage (
        .inst_i        (inst),
        .pc_data_i     (pc),
        .reg1_data_i   (rdata1),
        .reg2_data_i   (rdata2),
        .reg1_addr_o   (reg1_addr),
        .reg2_addr_o   (reg2_addr),
        .rd_addr_o     (rd_addr),
        .funct3_o      (funct3),
        .inst_alu30_o  (alu30),
        .pc_plus_o     (pc_plus),
        .branch_addr_o (branch_addr),
        .imm_o         (imm),
        .reg1_data_o   (reg1_data),
        .reg2_data_o   (reg2_data),
        .alu_op_o      (alu_op),
        .jump_o        (jump),
        .wb_sel_o      (wb_sel),
        .reg_we_o      (reg_we),
        .use_imm_o     (use_imm)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (reg1_addr),
        .raddr2_i (reg2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_we),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data)
    );

    ex_stage #(
        .PC_WIDTH (PC_WIDTH)
    ) u_ex_stage (
        .exec_i        (exec),
        .rd_addr_i     (rd_addr),
        .funct3_i      (funct3),
        .inst_alu30_i  (alu30),
        .alu_op_i      (alu_op),
        .jump_i        (jump),
        .wb_sel_i      (wb_sel),
        .reg_we_i      (reg_we),
        .use_imm_i     (use_imm),
        .imm_i         (imm),
        .pc_plus_i     (pc_plus),
        .branch_addr_i (branch_addr),
        .reg1_data_i   (reg1_data),
        .reg2_data_i   (reg2_data),
        .wb_we_o       (wb_we),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    // one retire per exec cycle
    assign retire_valid_o = exec;
    assign retire_pc_o    = pc;
    assign retire_rd_o    = wb_addr;
    assign retire_we_o    = wb_we;
    assign retire_data_o  = wb_data;

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import core_isa_pkg::*; import core_ctrl_pkg::*; #(
    parameter int PC_WIDTH = 16
) (
    input  logic                exec_i,

    input  reg_addr_t           rd_addr_i,
    input  funct3_t             funct3_i,
    input  logic                inst_alu30_i,
    input  alu_op_e             alu_op_i,
    input  jump_e               jump_i,
    input  wb_sel_e             wb_sel_i,
    input  logic                reg_we_i,
    input  logic                use_imm_i,
    input  word_t               imm_i,
    input  logic [PC_WIDTH-1:0] pc_plus_i,
    input  logic [PC_WIDTH-1:0] branch_addr_i,
    input  word_t               reg1_data_i,
    input  word_t               reg2_data_i,

    output logic                wb_we_o,
    output reg_addr_t           wb_addr_o,
    output word_t               wb_data_o,
    output logic                redirect_o,
    output logic [PC_WIDTH-1:0] redirect_pc_o
);

    word_t op_b;
    word_t alu_res;
    logic  taken;

    assign op_b = use_imm_i ? imm_i : reg2_data_i;

    always_comb begin
        alu_res = reg1_data_i + op_b;
        if (alu_op_i == ALU_PASS_IMM) begin
            alu_res = imm_i;
        end else if (alu_op_i == ALU_FUNCT) begin
            case (funct3_i)
                // sub only exists in the register form
                F3_ADD_SUB: alu_res = (inst_alu30_i && !use_imm_i) ?
                                      reg1_data_i - op_b : reg1_data_i + op_b;
                F3_SLT:     alu_res = {31'b0, $signed(reg1_data_i) < $signed(op_b)};
                F3_XOR:     alu_res = reg1_data_i ^ op_b;
                F3_OR:      alu_res = reg1_data_i | op_b;
                F3_AND:     alu_res = reg1_data_i & op_b;
                default:    alu_res = reg1_data_i + op_b;
            endcase
        end
    end

    // beq or bne
    assign taken = (funct3_i == F3_BNE) ? (reg1_data_i != reg2_data_i)
                                        : (reg1_data_i == reg2_data_i);

    assign redirect_o    = exec_i && ((jump_i == JUMP_BRANCH && taken) ||
                                      jump_i == JUMP_JAL);
    assign redirect_pc_o = branch_addr_i;

    assign wb_we_o   = exec_i && reg_we_i;
    assign wb_addr_o = rd_addr_i;
    assign wb_data_o = (wb_sel_i == WB_PC_PLUS) ? {{(32-PC_WIDTH){1'b0}}, pc_plus_i}
                                                : alu_res;

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps

module id_stage import core_isa_pkg::*; import core_ctrl_pkg::*; #(
    parameter int PC_WIDTH = 16
) (
    input  inst_t               inst_i,
    input  logic [PC_WIDTH-1:0] pc_data_i,

    // register file read port
    input  word_t               reg1_data_i,
    input  word_t               reg2_data_i,
    output reg_addr_t           reg1_addr_o,
    output reg_addr_t           reg2_addr_o,

    // decoded fields towards execute
    output reg_addr_t           rd_addr_o,
    output funct3_t             funct3_o,
    output logic                inst_alu30_o,
    output logic [PC_WIDTH-1:0] pc_plus_o,
    output logic [PC_WIDTH-1:0] branch_addr_o,
    output word_t               imm_o,
    output word_t               reg1_data_o,
    output word_t               reg2_data_o,

    // controls
    output alu_op_e             alu_op_o,
    output jump_e               jump_o,
    output wb_sel_e             wb_sel_o,
    output logic                reg_we_o,
    output logic                use_imm_o
);

    opcode_t opcode;
    word_t   branch_offset;

    assign opcode       = inst_i[OPCODE_LSB +: 7];
    assign rd_addr_o    = inst_i[RD_LSB +: 5];
    assign funct3_o     = inst_i[FUNCT3_LSB +: 3];
    assign inst_alu30_o = inst_i[ALT_BIT];

    assign reg1_addr_o = inst_i[RS1_LSB +: 5];
    assign reg2_addr_o = inst_i[RS2_LSB +: 5];
    assign reg1_data_o = reg1_data_i;
    assign reg2_data_o = reg2_data_i;

    control_unit u_control_unit (
        .opcode_i  (opcode),
        .alu_op_o  (alu_op_o),
        .jump_o    (jump_o),
        .wb_sel_o  (wb_sel_o),
        .reg_we_o  (reg_we_o),
        .use_imm_o (use_imm_o)
    );

    imm_gen u_imm_gen (
        .inst_i          (inst_i),
        .imm_o           (imm_o),
        .branch_offset_o (branch_offset)
    );

    // pc counts words, target is relative to pc + 1
    assign pc_plus_o     = pc_data_i + 1'b1;
    assign branch_addr_o = pc_plus_o + branch_offset[PC_WIDTH-1:0];

endmodule

// ==== hw/ifetch_wb.sv ====
`timescale 1ns/1ps

module ifetch_wb import core_isa_pkg::*; import core_ctrl_pkg::*; #(
    parameter int PC_WIDTH = 16
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    // wishbone classic instruction bus
    output logic                ibus_cyc_o,
    output logic                ibus_stb_o,
    output logic [PC_WIDTH-1:0] ibus_adr_o,
    input  inst_t               ibus_dat_i,
    input  logic                ibus_ack_i,

    // redirect from execute
    input  logic                redirect_i,
    input  logic [PC_WIDTH-1:0] redirect_pc_i,

    output inst_t               inst_o,
    output logic [PC_WIDTH-1:0] pc_o,
    output logic                exec_o
);

    fetch_state_e        state_q;
    logic [PC_WIDTH-1:0] pc_q;
    inst_t               inst_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FETCH_IDLE;
            pc_q    <= '0;
            inst_q  <= '0;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    state_q <= FETCH_REQ;
                end
                FETCH_REQ: begin
                    // hold everything until the slave answers
                    if (ibus_ack_i) begin
                        inst_q  <= ibus_dat_i;
                        state_q <= FETCH_EXEC;
                    end
                end
                FETCH_EXEC: begin
                    // instruction retires at this edge
                    pc_q    <= redirect_i ? redirect_pc_i : pc_q + 1'b1;
                    state_q <= FETCH_REQ;
                end
                default: begin
                    state_q <= FETCH_IDLE;
                end
            endcase
        end
    end

    assign ibus_cyc_o = (state_q == FETCH_REQ);
    assign ibus_stb_o = (state_q == FETCH_REQ);
    assign ibus_adr_o = pc_q;

    assign inst_o = inst_q;
    assign pc_o   = pc_q;
    assign exec_o = (state_q == FETCH_EXEC);

    a_stb_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ibus_stb_o |-> ibus_cyc_o);

    // a pending request keeps its address and strobe until ack
    a_adr_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ibus_stb_o && !ibus_ack_i) |=> (ibus_stb_o && $stable(ibus_adr_o)));

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen import core_isa_pkg::*; (
    input  inst_t inst_i,
    output word_t imm_o,
    output word_t branch_offset_o
);

    opcode_t opcode;
    word_t   b_offset;
    word_t   j_offset;

    assign opcode = inst_i[OPCODE_LSB +: 7];

    // byte offsets as encoded
    assign b_offset = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                       inst_i[30:25], inst_i[11:8], 1'b0};
    assign j_offset = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                       inst_i[20], inst_i[30:21], 1'b0};

    // u immediate for lui, sign-extended i immediate otherwise
    assign imm_o = (opcode == OP_LUI) ? {inst_i[31:12], 12'b0}
                                      : {{20{inst_i[31]}}, inst_i[31:20]};

    // word offset, low two bits dropped
    always_comb begin
        if (opcode == OP_JAL) begin
            branch_offset_o = $signed(j_offset) >>> 2;
        end else begin
            branch_offset_o = $signed(b_offset) >>> 2;
        end
    end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps

module regfile import core_isa_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,

    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired to zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_core -Mdir "$OBJ" -o Vtb_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$OBJ/Vtb_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
